// ==== Bender.yml ====
package:
  name: mem_subsystem

dependencies: {}

sources:
  # Packages first, then leaf modules, then the top level
  - src/mem_types_pkg.sv
  - src/soc_map_pkg.sv
  - src/handshake_fifo.sv
  - src/core_port.sv
  - src/ram_bank.sv
  - src/mem_subsystem.sv

  - target: test
    files:
      - verif/mem_subsystem_props.sv
      - verif/tb_mem_subsystem.sv

// ==== project.f ====
src/mem_types_pkg.sv
src/soc_map_pkg.sv
src/handshake_fifo.sv
src/core_port.sv
src/ram_bank.sv
src/mem_subsystem.sv
verif/mem_subsystem_props.sv
verif/tb_mem_subsystem.sv

// ==== src/core_port.sv ====
`timescale 1ns/1ps

module core_port import mem_types_pkg::*; (
    input  logic        clkConstrained,
    input  logic        arst_n,

    input  logic        inst_start,
    input  logic [31:0] i_addr,
    output logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_valid,

    input  logic        d_cmd_start,
    input  logic        d_cmd_write,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    output logic        d_cmd_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output mem_req_t    req_out,
    output logic        req_out_req,
    input  logic        req_out_ack,

    input  mem_rsp_t    rsp_in,
    input  logic        rsp_in_req,
    output logic        rsp_in_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_DROP
    } tx_state_t;

    tx_state_t   tx_state;
    logic        f_pend;
    logic        d_pend;
    logic [31:0] f_addr;
    mem_req_t    d_slot;
    logic        f_accept;
    logic        d_accept;
    logic        issue_data;
    logic        issue_fetch;
    logic        rsp_take;

    assign f_accept    = inst_start && inst_ready;
    assign d_accept    = d_cmd_start && d_cmd_ready;
    assign issue_data  = (tx_state == TX_IDLE) && d_pend;           // Data wins a tie
    assign issue_fetch = (tx_state == TX_IDLE) && !d_pend && f_pend;
    assign rsp_take    = rsp_in_req && !rsp_in_ack;
    assign req_out_req = (tx_state == TX_REQ);

    // Command slots and the outgoing request payload
    always_ff @(posedge clkConstrained) begin
        if (f_accept) begin
            f_addr <= i_addr;
        end
        if (d_accept) begin
            d_slot <= '{src: SRC_DATA, write: d_cmd_write, addr: d_addr,
                        wdata: wdata, wmask: wmask};
        end
        if (issue_data) begin
            req_out <= d_slot;
        end else if (issue_fetch) begin
            req_out <= '{src: SRC_FETCH, write: 1'b0, addr: f_addr,
                         wdata: '0, wmask: '0};
        end
        if (rsp_take && rsp_in.src == SRC_FETCH) begin
            inst <= rsp_in.rdata;
        end
        if (rsp_take && rsp_in.src == SRC_DATA && !rsp_in.write) begin
            rdata <= rsp_in.rdata;
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            f_pend   <= 1'b0;
            d_pend   <= 1'b0;
            tx_state <= TX_IDLE;
        end else begin
            if (f_accept) begin
                f_pend <= 1'b1;
            end else if (issue_fetch) begin
                f_pend <= 1'b0;
            end
            if (d_accept) begin
                d_pend <= 1'b1;
            end else if (issue_data) begin
                d_pend <= 1'b0;
            end
            case (tx_state)
                TX_IDLE: if (issue_data || issue_fetch) tx_state <= TX_REQ;
                TX_REQ:  if (req_out_ack) tx_state <= TX_DROP;
                TX_DROP: if (!req_out_ack) tx_state <= TX_IDLE;  // Wait for ack release
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Response receiver, valid pulses and ready return
    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            rsp_in_ack  <= 1'b0;
            inst_ready  <= 1'b1;
            d_cmd_ready <= 1'b1;
            inst_valid  <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            inst_valid  <= 1'b0;
            rdata_valid <= 1'b0;
            if (f_accept) begin
                inst_ready <= 1'b0;
            end
            if (d_accept) begin
                d_cmd_ready <= 1'b0;
            end
            if (rsp_take) begin
                rsp_in_ack <= 1'b1;
                if (rsp_in.src == SRC_FETCH) begin
                    inst_valid <= 1'b1;
                    inst_ready <= 1'b1;
                end else begin
                    rdata_valid <= !rsp_in.write;  // Writes only give ready back
                    d_cmd_ready <= 1'b1;
                end
            end else if (!rsp_in_req && rsp_in_ack) begin
                rsp_in_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== src/handshake_fifo.sv ====
`timescale 1ns/1ps

module handshake_fifo import soc_map_pkg::*; #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic     clkConstrained,
    input  logic     arst_n,

    input  payload_t in_data,
    input  logic     in_req,
    output logic     in_ack,

    output payload_t out_data,
    output logic     out_req,
    input  logic     out_ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_DROP
    } out_state_t;

    payload_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    out_state_t out_state;
    logic       full;
    logic       push;
    logic       pop;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign push     = in_req && !in_ack && !full;   // Full holds ack low
    assign pop      = (out_state == OUT_DROP) && !out_ack;
    assign out_req  = (out_state == OUT_REQ);
    assign out_data = mem[rd_ptr];                  // Head stays put until pop

    always_ff @(posedge clkConstrained) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            in_ack    <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_state <= OUT_IDLE;
        end else begin
            if (push) begin
                in_ack <= 1'b1;
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (!in_req && in_ack) begin
                in_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            case (out_state)
                OUT_IDLE: if (count != '0) out_state <= OUT_REQ;
                OUT_REQ:  if (out_ack) out_state <= OUT_DROP;
                OUT_DROP: if (!out_ack) out_state <= OUT_IDLE;  // Entry leaves here
                default:  out_state <= OUT_IDLE;
            endcase
        end
    end

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem import mem_types_pkg::*, soc_map_pkg::*; #(
    parameter int RAM_WORDS  = DEF_RAM_WORDS,
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic        clkConstrained,
    input  logic        arst_n,

    input  logic        inst_start,
    input  logic [31:0] i_addr,
    output logic        inst_ready,
    output logic [31:0] inst,
    output logic        inst_valid,

    input  logic        d_cmd_start,
    input  logic        d_cmd_write,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    output logic        d_cmd_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output logic [31:0] gp,
    output logic        exit
);

    // core_port to request FIFO
    mem_req_t cp_req;
    logic     cp_req_req;
    logic     cp_req_ack;
    // Request FIFO to ram_bank
    mem_req_t rb_req;
    logic     rb_req_req;
    logic     rb_req_ack;
    // ram_bank to response FIFO
    mem_rsp_t rb_rsp;
    logic     rb_rsp_req;
    logic     rb_rsp_ack;
    // Response FIFO back to core_port
    mem_rsp_t cp_rsp;
    logic     cp_rsp_req;
    logic     cp_rsp_ack;

    core_port u_core_port (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .inst_start     (inst_start),
        .i_addr         (i_addr),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .d_cmd_start    (d_cmd_start),
        .d_cmd_write    (d_cmd_write),
        .d_addr         (d_addr),
        .wdata          (wdata),
        .wmask          (wmask),
        .d_cmd_ready    (d_cmd_ready),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .req_out        (cp_req),
        .req_out_req    (cp_req_req),
        .req_out_ack    (cp_req_ack),
        .rsp_in         (cp_rsp),
        .rsp_in_req     (cp_rsp_req),
        .rsp_in_ack     (cp_rsp_ack)
    );

    handshake_fifo #(
        .payload_t  (mem_req_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .in_data        (cp_req),
        .in_req         (cp_req_req),
        .in_ack         (cp_req_ack),
        .out_data       (rb_req),
        .out_req        (rb_req_req),
        .out_ack        (rb_req_ack)
    );

    ram_bank #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram_bank (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .req_in         (rb_req),
        .req_in_req     (rb_req_req),
        .req_in_ack     (rb_req_ack),
        .rsp_out        (rb_rsp),
        .rsp_out_req    (rb_rsp_req),
        .rsp_out_ack    (rb_rsp_ack),
        .gp             (gp),
        .exit           (exit)
    );

    handshake_fifo #(
        .payload_t  (mem_rsp_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rsp_fifo (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .in_data        (rb_rsp),
        .in_req         (rb_rsp_req),
        .in_ack         (rb_rsp_ack),
        .out_data       (cp_rsp),
        .out_req        (cp_rsp_req),
        .out_ack        (cp_rsp_ack)
    );

endmodule

// ==== src/mem_types_pkg.sv ====
package mem_types_pkg;

    // Which core port a transaction belongs to
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } mem_src_t;

    // Request travelling from the core side towards the RAM
    typedef struct packed {
        mem_src_t    src;
        logic        write;
        logic [31:0] addr;   // Byte address, word aligned
        logic [31:0] wdata;
        logic [31:0] wmask;  // Per-bit enable, 1 = take wdata
    } mem_req_t;

    // Response travelling back to the core side
    typedef struct packed {
        mem_src_t    src;
        logic        write;  // Echo of the request, no data for writes
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

// ==== src/ram_bank.sv ====
`timescale 1ns/1ps

module ram_bank import mem_types_pkg::*, soc_map_pkg::*; #(
    parameter int RAM_WORDS = DEF_RAM_WORDS
) (
    input  logic        clkConstrained,
    input  logic        arst_n,

    input  mem_req_t    req_in,
    input  logic        req_in_req,
    output logic        req_in_ack,

    output mem_rsp_t    rsp_out,
    output logic        rsp_out_req,
    input  logic        rsp_out_ack,

    output logic [31:0] gp,
    output logic        exit
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    typedef enum logic [1:0] {
        RB_IDLE,
        RB_ACCESS,
        RB_RSP,
        RB_DROP
    } rb_state_t;

    logic [31:0]      ram [RAM_WORDS];
    rb_state_t        state;
    mem_req_t         req_q;
    logic [IDX_W-1:0] idx;
    logic             is_gp;
    logic             is_exit;
    logic             take;
    logic             access;
    logic             ram_we;
    logic [31:0]      rd_word;

    assign take        = (state == RB_IDLE) && req_in_req && !req_in_ack;
    assign access      = (state == RB_ACCESS);
    assign idx         = req_q.addr[IDX_W+1:2];           // Word index, wraps at RAM_WORDS
    assign is_gp       = (req_q.addr == GP_ADDR);
    assign is_exit     = (req_q.addr == EXIT_ADDR);
    assign ram_we      = access && req_q.write && !is_gp && !is_exit;
    assign rsp_out_req = (state == RB_RSP);

    always_comb begin
        if (is_gp) begin
            rd_word = gp;
        end else if (is_exit) begin
            rd_word = {31'b0, exit};
        end else begin
            rd_word = ram[idx];
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (take) begin
            req_q <= req_in;
        end
        if (ram_we) begin
            ram[idx] <= (ram[idx] & ~req_q.wmask) | (req_q.wdata & req_q.wmask);
        end
        if (access) begin
            rsp_out <= '{src: req_q.src, write: req_q.write, rdata: rd_word};
        end
    end

    always_ff @(posedge clkConstrained or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RB_IDLE;
            req_in_ack <= 1'b0;
            gp         <= '0;
            exit       <= 1'b0;
        end else begin
            if (take) begin
                req_in_ack <= 1'b1;
            end else if (!req_in_req && req_in_ack) begin
                req_in_ack <= 1'b0;
            end
            if (access && req_q.write && is_gp) begin
                gp <= (gp & ~req_q.wmask) | (req_q.wdata & req_q.wmask);
            end
            if (access && req_q.write && is_exit) begin
                exit <= 1'b1;                               // Sticky until reset
            end
            case (state)
                RB_IDLE:   if (take) state <= RB_ACCESS;
                RB_ACCESS: state <= RB_RSP;
                RB_RSP:    if (rsp_out_ack) state <= RB_DROP;
                RB_DROP:   if (!rsp_out_ack) state <= RB_IDLE;
                default:   state <= RB_IDLE;
            endcase
        end
    end

endmodule

// ==== src/soc_map_pkg.sv ====
package soc_map_pkg;

    // Memory-mapped registers sit well above the RAM window
    localparam logic [31:0] GP_ADDR   = 32'h8000_0000;
    localparam logic [31:0] EXIT_ADDR = 32'h8000_0004;

    // Defaults, overridden from the top level
    localparam int DEF_RAM_WORDS  = 256;  // Must stay a power of two
    localparam int DEF_FIFO_DEPTH = 4;

endpackage

// ==== verif/mem_subsystem_props.sv ====
`timescale 1ns/1ps

module mem_subsystem_props #(
    parameter int W = 1
) (
    input logic         clkConstrained,
    input logic         arst_n,
    input logic [W-1:0] in_data,
    input logic         in_req,
    input logic         in_ack
);

    int fail_cnt = 0;

    // Sender holds req until the receiver acknowledges
    req_held: assert property (@(posedge clkConstrained) disable iff (!arst_n)
        in_req && !in_ack |=> in_req)
        else begin
            fail_cnt++;
            $error("in_req dropped before in_ack rose");
        end

    data_stable: assert property (@(posedge clkConstrained) disable iff (!arst_n)
        in_req && $past(in_req) |-> $stable(in_data))
        else begin
            fail_cnt++;
            $error("in_data changed while in_req was high");
        end

    ack_needs_req: assert property (@(posedge clkConstrained) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else begin
            fail_cnt++;
            $error("in_ack rose without in_req");
        end

endmodule

bind handshake_fifo mem_subsystem_props #(
    .W ($bits(payload_t))
) u_props (
    .clkConstrained (clkConstrained),
    .arst_n         (arst_n),
    .in_data        (in_data),
    .in_req         (in_req),
    .in_ack         (in_ack)
);

// ==== verif/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem import soc_map_pkg::*; ();

    localparam int RAM_WORDS  = DEF_RAM_WORDS;
    localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
    localparam int TIMEOUT    = 200;  // Cycles per wait loop

    logic        clkConstrained;
    logic        arst_n;
    logic        inst_start;
    logic [31:0] i_addr;
    logic        inst_ready;
    logic [31:0] inst;
    logic        inst_valid;
    logic        d_cmd_start;
    logic        d_cmd_write;
    logic [31:0] d_addr;
    logic [31:0] wdata;
    logic [31:0] wmask;
    logic        d_cmd_ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic [31:0] gp;
    logic        exit;

    logic [31:0] lfsr = 32'h75ff1a1f;
    logic [31:0] model_mem [int];     // Written words by word index
    logic [31:0] addr_q [$];          // Addresses known to hold data

    mem_subsystem #(
        .RAM_WORDS  (RAM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_mem_subsystem (
        .clkConstrained (clkConstrained),
        .arst_n         (arst_n),
        .inst_start     (inst_start),
        .i_addr         (i_addr),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .d_cmd_start    (d_cmd_start),
        .d_cmd_write    (d_cmd_write),
        .d_addr         (d_addr),
        .wdata          (wdata),
        .wmask          (wmask),
        .d_cmd_ready    (d_cmd_ready),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .gp             (gp),
        .exit           (exit)
    );

    initial begin
        clkConstrained = 1'b0;
        forever #2 clkConstrained = ~clkConstrained;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int word_idx(input logic [31:0] addr);
        return int'((addr >> 2) % RAM_WORDS);
    endfunction

    // Each bit with its mask bit set takes the new data
    function automatic logic [31:0] apply_mask(input logic [31:0] old, dat, mask);
        logic [31:0] res;
        for (int b = 0; b < 32; b++) begin
            res[b] = mask[b] ? dat[b] : old[b];
        end
        return res;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return model_mem[word_idx(addr)];
    endfunction

    function automatic void model_write(input logic [31:0] addr, dat, mask);
        logic [31:0] old;
        old = model_mem.exists(word_idx(addr)) ? model_mem[word_idx(addr)] : 32'h0;
        model_mem[word_idx(addr)] = apply_mask(old, dat, mask);
    endfunction

    function automatic logic [31:0] pick_addr();
        return addr_q[rand_bits(8) % addr_q.size()];
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // Called on a falling edge and returns on the falling edge that completes the command
    task automatic data_access(input logic wr, input logic [31:0] addr, dat, mask,
                               input int delay, output logic [31:0] rd);
        int n;
        repeat (delay) @(negedge clkConstrained);
        n = 0;
        while (!d_cmd_ready) begin
            @(negedge clkConstrained);
            n++;
            if (n > TIMEOUT) fail_timeout("data port never became ready");
        end
        d_cmd_start = 1'b1;
        d_cmd_write = wr;
        d_addr      = addr;
        wdata       = dat;
        wmask       = mask;
        @(negedge clkConstrained);
        d_cmd_start = 1'b0;
        n = 0;
        while (wr ? !d_cmd_ready : !rdata_valid) begin
            check("d_cmd_ready low while busy", 32'd0, 32'(d_cmd_ready));
            check("no rdata_valid while busy", 32'd0, 32'(rdata_valid));
            @(negedge clkConstrained);
            n++;
            if (n > TIMEOUT) fail_timeout("data command never completed");
        end
        check("d_cmd_ready returns", 32'd1, 32'(d_cmd_ready));
        check("rdata_valid only for reads", wr ? 32'd0 : 32'd1, 32'(rdata_valid));
        rd = rdata;
    endtask

    task automatic fetch(input logic [31:0] addr, input int delay, output logic [31:0] rd);
        int n;
        repeat (delay) @(negedge clkConstrained);
        n = 0;
        while (!inst_ready) begin
            @(negedge clkConstrained);
            n++;
            if (n > TIMEOUT) fail_timeout("fetch port never became ready");
        end
        inst_start = 1'b1;
        i_addr     = addr;
        @(negedge clkConstrained);
        inst_start = 1'b0;
        n = 0;
        while (!inst_valid) begin
            check("inst_ready low while busy", 32'd0, 32'(inst_ready));
            @(negedge clkConstrained);
            n++;
            if (n > TIMEOUT) fail_timeout("fetch never returned inst_valid");
        end
        check("inst_ready returns", 32'd1, 32'(inst_ready));
        rd = inst;
    endtask

    initial begin
        logic [31:0] addr, dat, mask, rd, model_gp;
        logic [31:0] daddr, faddr, exp_d, exp_f, d_rd, f_rd;
        logic        wr;
        int          ddly, fdly;
        arst_n      = 1'b0;
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        repeat (5) @(negedge clkConstrained);
        arst_n = 1'b1;
        @(negedge clkConstrained);
        check("reset inst_ready", 32'd1, 32'(inst_ready));
        check("reset d_cmd_ready", 32'd1, 32'(d_cmd_ready));
        check("reset inst_valid", 32'd0, 32'(inst_valid));
        check("reset rdata_valid", 32'd0, 32'(rdata_valid));
        check("reset gp", 32'd0, gp);
        check("reset exit", 32'd0, 32'(exit));

        // Word index 14 bits wide, so addresses alias modulo RAM_WORDS
        for (int i = 0; i < 48; i++) begin
            addr = {16'h0, 14'(rand_bits(14)), 2'b00};
            dat  = rand_bits(32);
            data_access(1'b1, addr, dat, 32'hffff_ffff, 0, rd);
            model_write(addr, dat, 32'hffff_ffff);
            addr_q.push_back(addr);
        end
        foreach (addr_q[k]) begin
            data_access(1'b0, addr_q[k], 32'h0, 32'h0, 0, rd);
            check("full-word read", model_word(addr_q[k]), rd);
            fetch(addr_q[k], 0, rd);
            check("full-word fetch", model_word(addr_q[k]), rd);
        end

        for (int i = 0; i < 32; i++) begin
            addr = pick_addr();
            dat  = rand_bits(32);
            mask = rand_bits(32);
            data_access(1'b1, addr, dat, mask, 0, rd);
            model_write(addr, dat, mask);
            data_access(1'b0, addr, 32'h0, 32'h0, 0, rd);
            check("masked write", model_word(addr), rd);
        end

        model_gp = 32'h0;
        for (int i = 0; i < 4; i++) begin
            dat  = rand_bits(32);
            mask = rand_bits(32);
            data_access(1'b1, GP_ADDR, dat, mask, 0, rd);
            model_gp = apply_mask(model_gp, dat, mask);
            check("gp output", model_gp, gp);
            data_access(1'b0, GP_ADDR, 32'h0, 32'h0, 0, rd);
            check("gp read", model_gp, rd);
        end
        check("exit before write", 32'd0, 32'(exit));
        data_access(1'b1, EXIT_ADDR, rand_bits(32), 32'hffff_ffff, 0, rd);
        check("exit set", 32'd1, 32'(exit));

        for (int i = 0; i < 64; i++) begin
            wr    = rand_bits(1) != 32'd0;
            daddr = pick_addr();
            faddr = (rand_bits(1) != 32'd0) ? daddr : pick_addr();
            dat   = rand_bits(32);
            mask  = rand_bits(32);
            ddly  = (i < 8) ? 0 : int'(rand_bits(2));  // First pairs start together
            fdly  = (i < 8) ? 0 : int'(rand_bits(2));
            // RAM order follows acceptance and a tie goes to the data port
            exp_f = model_word(faddr);
            if (wr) model_write(daddr, dat, mask);
            exp_d = model_word(daddr);
            if (ddly <= fdly) exp_f = model_word(faddr);
            fork
                data_access(wr, daddr, dat, mask, ddly, d_rd);
                fetch(faddr, fdly, f_rd);
            join
            if (!wr) check("overlap data read", exp_d, d_rd);
            check("overlap fetch", exp_f, f_rd);
            check("exit stays set", 32'd1, 32'(exit));
            check("gp unchanged", model_gp, gp);
        end

        check("bound assertion failures", 32'd0,
              32'(u_mem_subsystem.u_req_fifo.u_props.fail_cnt
                  + u_mem_subsystem.u_rsp_fifo.u_props.fail_cnt));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
